//--- src/i3c_target_pkg.sv
// Shared widths, reserved address, vector types, config/event structs and target FSM states
package i3c_target_pkg;

  localparam int unsigned BYTE_W = 8;
  localparam int unsigned WORD_W = 32;
  localparam int unsigned BYTES_PER_WORD = 4;
  localparam int unsigned TIMING_W = 20;
  localparam logic [6:0] RSVD_ADDR = 7'h7E;

  typedef logic [BYTE_W-1:0] byte_t;
  typedef logic [WORD_W-1:0] word_t;
  // Counted in clk_i cycles
  typedef logic [TIMING_W-1:0] timing_t;
  typedef logic [6:0] addr_t;

  typedef struct packed {
    timing_t t_su_dat;
    timing_t t_hd_dat;
    timing_t t_r;
    timing_t t_bus_free;
    timing_t t_bus_idle;
    timing_t t_bus_available;
  } bus_timing_t;

  typedef struct packed {
    addr_t static_addr;
    addr_t dyn_addr;
    logic  dyn_addr_valid;
  } addr_cfg_t;

  // Single-cycle pulses
  typedef struct packed {
    logic cmd_complete;
    logic read_cmd_received;
    logic target_nack;
    logic unexp_stop;
  } bus_events_t;

  typedef struct packed {
    logic sta;
    logic dyn;
    logic rsvd;
    logic any;
  } match_t;

  typedef enum logic [2:0] {
    IDLE,
    ADDR,
    ADDR_ACK,
    RX_DATA,
    RX_ACK,
    TX_DATA,
    TX_ACK,
    WAIT_STOP
  } tgt_state_e;

endpackage

//--- src/bus_monitor.sv
// SCL/SDA synchronizer with edge and START/STOP detection
`timescale 1ns/1ps

module bus_monitor (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic enable_i,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_o,
  output logic sda_o,
  output logic scl_rise_o,
  output logic scl_fall_o,
  output logic start_det_o,
  output logic stop_det_o
);

  // Bit 1 is SCL, bit 0 is SDA
  logic [1:0] sync1_q;
  logic [1:0] sync2_q;
  logic [1:0] prev_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync1_q     <= 2'b11;
      sync2_q     <= 2'b11;
      prev_q      <= 2'b11;
      scl_rise_o  <= 1'b0;
      scl_fall_o  <= 1'b0;
      start_det_o <= 1'b0;
      stop_det_o  <= 1'b0;
    end else begin
      sync1_q     <= {scl_i, sda_i};
      sync2_q     <= sync1_q;
      prev_q      <= sync2_q;
      scl_rise_o  <= enable_i && sync2_q[1] && !prev_q[1];
      scl_fall_o  <= enable_i && !sync2_q[1] && prev_q[1];
      // SDA edge while SCL stays high
      start_det_o <= enable_i && sync2_q[1] && prev_q[1] && !sync2_q[0] && prev_q[0];
      stop_det_o  <= enable_i && sync2_q[1] && prev_q[1] && sync2_q[0] && !prev_q[0];
    end
  end

  // Levels line up with the registered pulses
  assign scl_o = prev_q[1];
  assign sda_o = prev_q[0];

endmodule

//--- src/bus_timers.sv
// Bus-free, bus-idle and bus-available timers started by STOP
`timescale 1ns/1ps

module bus_timers (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        enable_i,
  input  logic                        start_det_i,
  input  logic                        stop_det_i,
  input  logic                        scl_i,
  input  logic                        sda_i,
  input  i3c_target_pkg::bus_timing_t timing_i,
  output logic                        bus_free_o,
  output logic                        bus_idle_o,
  output logic                        bus_available_o
);

  i3c_target_pkg::timing_t cnt_q;
  logic                    stop_seen_q;
  logic [2:0]              hit;
  logic [2:0]              cond_q;

  assign hit = {cnt_q >= timing_i.t_bus_available,
                cnt_q >= timing_i.t_bus_idle,
                cnt_q >= timing_i.t_bus_free};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q       <= '0;
      stop_seen_q <= 1'b0;
      cond_q      <= '0;
    end else if (!enable_i || start_det_i) begin
      cnt_q       <= '0;
      stop_seen_q <= 1'b0;
      cond_q      <= '0;
    end else if (stop_det_i) begin
      cnt_q       <= '0;
      stop_seen_q <= 1'b1;
    end else if (stop_seen_q) begin
      // Saturate at all ones
      if (cnt_q != '1) begin
        cnt_q <= cnt_q + i3c_target_pkg::TIMING_W'(1);
      end
      if (scl_i && sda_i) begin
        cond_q <= cond_q | hit;
      end
    end
  end

  assign bus_free_o      = cond_q[0];
  assign bus_idle_o      = cond_q[1];
  assign bus_available_o = cond_q[2];

endmodule

//--- src/addr_match.sv
// Address comparison against static, dynamic and broadcast addresses
`timescale 1ns/1ps

module addr_match (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  i3c_target_pkg::addr_cfg_t cfg_i,
  input  i3c_target_pkg::addr_t     bus_addr_i,
  input  logic                      bus_addr_valid_i,
  output i3c_target_pkg::match_t    match_o
);

  i3c_target_pkg::match_t match_d;

  // Broadcast is write-only; the FSM applies the direction
  always_comb begin
    match_d.sta  = bus_addr_i == cfg_i.static_addr;
    match_d.dyn  = cfg_i.dyn_addr_valid && (bus_addr_i == cfg_i.dyn_addr);
    match_d.rsvd = bus_addr_i == i3c_target_pkg::RSVD_ADDR;
    match_d.any  = match_d.sta || match_d.dyn || match_d.rsvd;
  end

  // Held for the rest of the transfer
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      match_o <= '0;
    end else if (bus_addr_valid_i) begin
      match_o <= match_d;
    end
  end

endmodule

//--- src/i3c_target_fsm.sv
// Bit-level I3C target FSM with byte shifting, ACK handling and SDA hold timing
`timescale 1ns/1ps

module i3c_target_fsm (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        enable_i,
  input  logic                        scl_rise_i,
  input  logic                        scl_fall_i,
  input  logic                        sda_i,
  input  logic                        start_det_i,
  input  logic                        stop_det_i,
  input  i3c_target_pkg::bus_timing_t timing_i,
  input  i3c_target_pkg::match_t      match_i,
  input  logic                        rx_byte_ready_i,
  input  logic                        tx_byte_valid_i,
  input  i3c_target_pkg::byte_t       tx_byte_i,
  output logic                        sda_o,
  output i3c_target_pkg::addr_t       bus_addr_o,
  output logic                        bus_addr_valid_o,
  output logic                        rx_byte_valid_o,
  output i3c_target_pkg::byte_t       rx_byte_o,
  output logic                        tx_byte_ready_o,
  output logic                        transfer_start_o,
  output logic                        transfer_stop_o,
  output i3c_target_pkg::bus_events_t events_o
);

  i3c_target_pkg::tgt_state_e  state_q;
  i3c_target_pkg::tgt_state_e  state_d;
  logic [3:0]                  bit_cnt_q;
  i3c_target_pkg::byte_t       shift_q;
  i3c_target_pkg::byte_t       tx_data;
  i3c_target_pkg::timing_t     hd_cnt_q;
  i3c_target_pkg::bus_events_t events_d;
  logic                        rw_q;
  logic                        ack_q;
  logic                        discard_q;
  logic                        addressed_q;
  logic                        hd_pend_q;
  logic                        sda_nxt_q;
  logic                        drive_req;
  logic                        drive_val;
  logic                        byte_done;
  logic                        addr_done;
  logic                        addr_ack;
  logic                        rx_done;
  logic                        in_byte;

  assign byte_done = bit_cnt_q == 4'd8;
  assign addr_done = scl_fall_i && (state_q == i3c_target_pkg::ADDR) && byte_done;
  assign rx_done   = scl_fall_i && (state_q == i3c_target_pkg::RX_DATA) && byte_done;
  assign addr_ack  = match_i.any && !(rw_q && match_i.rsvd);
  assign in_byte   = state_q inside {i3c_target_pkg::ADDR, i3c_target_pkg::RX_DATA,
                                     i3c_target_pkg::TX_DATA};
  // Empty TX buffer reads as all ones
  assign tx_data   = tx_byte_valid_i ? tx_byte_i : 8'hFF;

  assign bus_addr_o       = shift_q[6:0];
  assign rx_byte_o        = shift_q;
  assign rx_byte_valid_o  = rx_done && !discard_q;
  assign transfer_start_o = start_det_i;
  assign transfer_stop_o  = stop_det_i;

  // Transitions and SDA updates happen on SCL falling edges
  always_comb begin
    state_d         = state_q;
    drive_req       = 1'b0;
    drive_val       = 1'b1;
    tx_byte_ready_o = 1'b0;
    if (scl_fall_i) begin
      unique case (state_q)
        i3c_target_pkg::ADDR: begin
          if (byte_done) begin
            state_d   = i3c_target_pkg::ADDR_ACK;
            drive_req = 1'b1;
            drive_val = !addr_ack;
          end
        end
        i3c_target_pkg::ADDR_ACK: begin
          drive_req = 1'b1;
          if (!ack_q) begin
            state_d = i3c_target_pkg::WAIT_STOP;
          end else if (rw_q) begin
            state_d         = i3c_target_pkg::TX_DATA;
            tx_byte_ready_o = 1'b1;
            drive_val       = tx_data[7];
          end else begin
            state_d = i3c_target_pkg::RX_DATA;
          end
        end
        i3c_target_pkg::RX_DATA: begin
          if (byte_done) begin
            state_d   = i3c_target_pkg::RX_ACK;
            drive_req = 1'b1;
            drive_val = !(discard_q || rx_byte_ready_i);
          end
        end
        i3c_target_pkg::RX_ACK: begin
          drive_req = 1'b1;
          state_d   = ack_q ? i3c_target_pkg::RX_DATA : i3c_target_pkg::WAIT_STOP;
        end
        i3c_target_pkg::TX_DATA: begin
          drive_req = 1'b1;
          if (byte_done) begin
            state_d = i3c_target_pkg::TX_ACK;
          end else begin
            drive_val = shift_q[7];
          end
        end
        i3c_target_pkg::TX_ACK: begin
          if (ack_q) begin
            state_d         = i3c_target_pkg::TX_DATA;
            tx_byte_ready_o = 1'b1;
            drive_req       = 1'b1;
            drive_val       = tx_data[7];
          end else begin
            state_d = i3c_target_pkg::WAIT_STOP;
          end
        end
        default: begin
        end
      endcase
    end
    if (!enable_i || stop_det_i) begin
      state_d = i3c_target_pkg::IDLE;
    end else if (start_det_i) begin
      state_d = i3c_target_pkg::ADDR;
    end
  end

  // A regular STOP costs one SCL rise, so a real partial byte has more
  always_comb begin
    events_d.cmd_complete      = stop_det_i && addressed_q;
    events_d.read_cmd_received = addr_done && addr_ack && rw_q;
    events_d.target_nack       = rx_done && !discard_q && !rx_byte_ready_i;
    events_d.unexp_stop        = stop_det_i && in_byte && (bit_cnt_q > 4'd1);
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q          <= i3c_target_pkg::IDLE;
      bit_cnt_q        <= '0;
      rw_q             <= 1'b0;
      ack_q            <= 1'b0;
      discard_q        <= 1'b0;
      addressed_q      <= 1'b0;
      bus_addr_valid_o <= 1'b0;
      events_o         <= '0;
    end else begin
      state_q          <= state_d;
      events_o         <= events_d;
      bus_addr_valid_o <= scl_rise_i && (state_q == i3c_target_pkg::ADDR) &&
                          (bit_cnt_q == 4'd6);
      if (start_det_i || (state_d != state_q)) begin
        bit_cnt_q <= '0;
      end else if (scl_rise_i && !byte_done) begin
        bit_cnt_q <= bit_cnt_q + 4'd1;
      end
      if (scl_rise_i && (state_q == i3c_target_pkg::ADDR) && (bit_cnt_q == 4'd7)) begin
        rw_q <= sda_i;
      end
      if (addr_done) begin
        ack_q     <= addr_ack;
        discard_q <= match_i.rsvd;
      end else if (rx_done) begin
        ack_q <= discard_q || rx_byte_ready_i;
      end else if (scl_rise_i && (state_q == i3c_target_pkg::TX_ACK)) begin
        // Master ACK is SDA low
        ack_q <= !sda_i;
      end
      if (stop_det_i) begin
        addressed_q <= 1'b0;
      end else if (addr_done && addr_ack) begin
        addressed_q <= 1'b1;
      end
    end
  end

  // SDA hold delay after SCL falls
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hd_pend_q <= 1'b0;
      sda_o     <= 1'b1;
    end else if (!enable_i || start_det_i || stop_det_i) begin
      hd_pend_q <= 1'b0;
      sda_o     <= 1'b1;
    end else if (drive_req) begin
      hd_pend_q <= 1'b1;
    end else if (hd_pend_q && (hd_cnt_q <= i3c_target_pkg::TIMING_W'(1))) begin
      hd_pend_q <= 1'b0;
      sda_o     <= sda_nxt_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tx_byte_ready_o) begin
      shift_q <= tx_data;
    end else if (scl_rise_i) begin
      shift_q <= {shift_q[6:0], sda_i};
    end
    if (drive_req) begin
      hd_cnt_q  <= timing_i.t_hd_dat;
      sda_nxt_q <= drive_val;
    end else if (hd_pend_q) begin
      hd_cnt_q <= hd_cnt_q - i3c_target_pkg::TIMING_W'(1);
    end
  end

endmodule

//--- src/flow_standby_i3c.sv
// RX byte-to-word packing and TX word-to-byte unpacking
`timescale 1ns/1ps

module flow_standby_i3c (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  enable_i,
  input  logic                  transfer_start_i,
  input  logic                  transfer_stop_i,
  input  logic                  rx_byte_valid_i,
  input  i3c_target_pkg::byte_t rx_byte_i,
  input  logic                  tx_byte_ready_i,
  input  logic                  rx_queue_wready_i,
  input  logic                  tx_queue_rvalid_i,
  input  i3c_target_pkg::word_t tx_queue_rdata_i,
  output logic                  rx_byte_ready_o,
  output logic                  tx_byte_valid_o,
  output i3c_target_pkg::byte_t tx_byte_o,
  output logic                  rx_queue_wvalid_o,
  output i3c_target_pkg::word_t rx_queue_wdata_o,
  output logic                  tx_queue_rready_o
);

  logic [$clog2(i3c_target_pkg::BYTES_PER_WORD)-1:0] rx_cnt_q;
  logic [$clog2(i3c_target_pkg::BYTES_PER_WORD)-1:0] tx_idx_q;
  i3c_target_pkg::word_t asm_q;
  i3c_target_pkg::word_t asm_nxt;
  i3c_target_pkg::word_t pend_q;
  i3c_target_pkg::word_t tx_buf_q;
  logic                  pend_valid_q;
  logic                  tx_valid_q;
  logic                  rready_q;
  logic                  boundary;
  logic                  rx_take;
  logic                  rx_emit;
  logic                  rx_flush;
  logic                  tx_fetch;

  assign boundary = transfer_start_i || transfer_stop_i;
  assign rx_take  = rx_byte_valid_i && rx_byte_ready_o;
  assign rx_emit  = rx_take && (rx_cnt_q == '1);
  assign rx_flush = !rx_take && boundary && (rx_cnt_q != '0);
  assign tx_fetch = rready_q && tx_queue_rvalid_i;

  // No new bytes while a word waits for the queue
  assign rx_byte_ready_o   = enable_i && !pend_valid_q;
  assign rx_queue_wvalid_o = pend_valid_q;
  assign rx_queue_wdata_o  = pend_q;

  assign tx_byte_valid_o   = tx_valid_q;
  assign tx_byte_o         = tx_buf_q[tx_idx_q*i3c_target_pkg::BYTE_W +: i3c_target_pkg::BYTE_W];
  assign tx_queue_rready_o = rready_q;

  // Byte 0 lands in bits 7:0
  always_comb begin
    asm_nxt = asm_q;
    asm_nxt[rx_cnt_q*i3c_target_pkg::BYTE_W +: i3c_target_pkg::BYTE_W] = rx_byte_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_cnt_q     <= '0;
      asm_q        <= '0;
      pend_valid_q <= 1'b0;
    end else begin
      if (pend_valid_q && rx_queue_wready_i) begin
        pend_valid_q <= 1'b0;
      end
      if (rx_emit || rx_flush) begin
        pend_valid_q <= 1'b1;
        asm_q        <= '0;
        rx_cnt_q     <= '0;
      end else if (rx_take) begin
        asm_q    <= asm_nxt;
        rx_cnt_q <= rx_cnt_q + 1'b1;
      end
    end
  end

  // Fetch only into an empty buffer; a word not yet started survives a STOP
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_valid_q <= 1'b0;
      tx_idx_q   <= '0;
      rready_q   <= 1'b0;
    end else begin
      rready_q <= enable_i && !tx_valid_q && !rready_q && tx_queue_rvalid_i;
      if (tx_fetch) begin
        tx_valid_q <= 1'b1;
        tx_idx_q   <= '0;
      end else if (boundary && (tx_idx_q != '0)) begin
        tx_valid_q <= 1'b0;
        tx_idx_q   <= '0;
      end else if (tx_byte_ready_i && tx_valid_q) begin
        tx_idx_q <= tx_idx_q + 1'b1;
        if (tx_idx_q == '1) begin
          tx_valid_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_emit) begin
      pend_q <= asm_nxt;
    end else if (rx_flush) begin
      pend_q <= asm_q;
    end
    if (tx_fetch) begin
      tx_buf_q <= tx_queue_rdata_i;
    end
  end

endmodule

//--- src/controller_standby_i3c.sv
// Standby I3C controller top: bus monitor, timers, address match, target FSM and flow
`timescale 1ns/1ps

module controller_standby_i3c (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        ctrl_scl_i,
  input  logic                        ctrl_sda_i,
  output logic                        ctrl_scl_o,
  output logic                        ctrl_sda_o,
  input  logic                        i3c_standby_en_i,
  input  i3c_target_pkg::bus_timing_t timing_i,
  input  i3c_target_pkg::addr_cfg_t   addr_cfg_i,
  output logic                        rx_queue_wvalid_o,
  input  logic                        rx_queue_wready_i,
  output i3c_target_pkg::word_t       rx_queue_wdata_o,
  input  logic                        tx_queue_rvalid_i,
  output logic                        tx_queue_rready_o,
  input  i3c_target_pkg::word_t       tx_queue_rdata_i,
  output logic                        event_cmd_complete_o,
  output logic                        event_read_cmd_received_o,
  output logic                        event_target_nack_o,
  output logic                        event_unexp_stop_o,
  output logic                        bus_available_o,
  output logic                        bus_idle_o
);

  logic                        scl;
  logic                        sda;
  logic                        scl_rise;
  logic                        scl_fall;
  logic                        start_det;
  logic                        stop_det;
  i3c_target_pkg::addr_t       bus_addr;
  logic                        bus_addr_valid;
  i3c_target_pkg::match_t      match;
  logic                        rx_byte_valid;
  i3c_target_pkg::byte_t       rx_byte;
  logic                        rx_byte_ready;
  logic                        tx_byte_valid;
  i3c_target_pkg::byte_t       tx_byte;
  logic                        tx_byte_ready;
  logic                        transfer_start;
  logic                        transfer_stop;
  i3c_target_pkg::bus_events_t events;

  // Target never stretches SCL
  assign ctrl_scl_o = 1'b1;

  assign event_cmd_complete_o      = events.cmd_complete;
  assign event_read_cmd_received_o = events.read_cmd_received;
  assign event_target_nack_o       = events.target_nack;
  assign event_unexp_stop_o        = events.unexp_stop;

  bus_monitor xbus_monitor (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .enable_i(i3c_standby_en_i),
    .scl_i(ctrl_scl_i), .sda_i(ctrl_sda_i), .scl_o(scl), .sda_o(sda),
    .scl_rise_o(scl_rise), .scl_fall_o(scl_fall),
    .start_det_o(start_det), .stop_det_o(stop_det)
  );

  bus_timers xbus_timers (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .enable_i(i3c_standby_en_i),
    .start_det_i(start_det), .stop_det_i(stop_det), .scl_i(scl), .sda_i(sda),
    .timing_i(timing_i), .bus_free_o(), .bus_idle_o(bus_idle_o),
    .bus_available_o(bus_available_o)
  );

  addr_match xaddr_match (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .cfg_i(addr_cfg_i),
    .bus_addr_i(bus_addr), .bus_addr_valid_i(bus_addr_valid), .match_o(match)
  );

  i3c_target_fsm xi3c_target_fsm (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .enable_i(i3c_standby_en_i),
    .scl_rise_i(scl_rise), .scl_fall_i(scl_fall), .sda_i(sda),
    .start_det_i(start_det), .stop_det_i(stop_det), .timing_i(timing_i),
    .match_i(match), .rx_byte_ready_i(rx_byte_ready),
    .tx_byte_valid_i(tx_byte_valid), .tx_byte_i(tx_byte), .sda_o(ctrl_sda_o),
    .bus_addr_o(bus_addr), .bus_addr_valid_o(bus_addr_valid),
    .rx_byte_valid_o(rx_byte_valid), .rx_byte_o(rx_byte),
    .tx_byte_ready_o(tx_byte_ready), .transfer_start_o(transfer_start),
    .transfer_stop_o(transfer_stop), .events_o(events)
  );

  flow_standby_i3c xflow_standby_i3c (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .enable_i(i3c_standby_en_i),
    .transfer_start_i(transfer_start), .transfer_stop_i(transfer_stop),
    .rx_byte_valid_i(rx_byte_valid), .rx_byte_i(rx_byte),
    .tx_byte_ready_i(tx_byte_ready), .rx_queue_wready_i(rx_queue_wready_i),
    .tx_queue_rvalid_i(tx_queue_rvalid_i), .tx_queue_rdata_i(tx_queue_rdata_i),
    .rx_byte_ready_o(rx_byte_ready), .tx_byte_valid_o(tx_byte_valid),
    .tx_byte_o(tx_byte), .rx_queue_wvalid_o(rx_queue_wvalid_o),
    .rx_queue_wdata_o(rx_queue_wdata_o), .tx_queue_rready_o(tx_queue_rready_o)
  );

endmodule

//--- sim/tb_clk_gen.sv
// Testbench clock source, 10 ns period
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #5 clk_o = ~clk_o;

endmodule

//--- sim/tb_controller_standby_i3c.sv
// Testbench top: bus-master model, RX/TX queue models, transfer table and checks
`timescale 1ns/1ps

module tb_controller_standby_i3c;

  localparam int N_ROWS = 7;
  localparam int TIMEOUT = 2000;
  localparam int COND_IDLE = 0;
  localparam int COND_AVAIL = 1;
  localparam int COND_BUSY = 2;
  localparam int COND_WORDS = 3;

  // Row fields are direction, address, byte count, data bytes with byte 0 in bits 7:0,
  // expected address ACK, RX stall, data bits before an early STOP and TX words released
  typedef struct packed {
    logic        rw;
    logic [6:0]  addr;
    logic [3:0]  n_bytes;
    logic [63:0] data;
    logic        exp_ack;
    logic        stall;
    logic [3:0]  abort_bits;
    logic [1:0]  n_tx;
  } xfer_t;

  logic                        clk;
  logic                        rst_n = 1'b0;
  logic                        scl_m = 1'b1;
  logic                        sda_m = 1'b1;
  logic                        standby_en = 1'b1;
  logic                        rx_wready = 1'b0;
  logic                        tx_rvalid = 1'b0;
  i3c_target_pkg::word_t       tx_rdata = '0;
  i3c_target_pkg::bus_timing_t timing;
  i3c_target_pkg::addr_cfg_t   addr_cfg;
  logic                        scl_o;
  logic                        sda_o;
  logic                        rx_wvalid;
  i3c_target_pkg::word_t       rx_wdata;
  logic                        tx_rready;
  logic                        ev_cmd;
  logic                        ev_rd;
  logic                        ev_nack;
  logic                        ev_unexp;
  logic                        bus_avail;
  logic                        bus_idle;
  logic                        scl_bus;
  logic                        sda_bus;

  xfer_t                 rows [N_ROWS];
  i3c_target_pkg::word_t rx_q [$];
  i3c_target_pkg::word_t tx_words [2] = '{32'h4433_2211, 32'h8877_6655};
  int                    tx_count = 0;
  int                    tx_idx = 0;
  logic                  tx_pop = 1'b0;
  logic                  stall_q = 1'b0;
  int unsigned           lcg_state = 88;
  int                    cnt_cmd = 0;
  int                    cnt_rd = 0;
  int                    cnt_nack = 0;
  int                    cnt_unexp = 0;

  // t_su_dat, t_hd_dat, t_r, t_bus_free, t_bus_idle, t_bus_available
  assign timing   = {20'd2, 20'd3, 20'd2, 20'd30, 20'd60, 20'd100};
  assign addr_cfg = {7'h22, 7'h5A, 1'b1};

  // Open-drain wired AND of master and target
  assign scl_bus = scl_m & scl_o;
  assign sda_bus = sda_m & sda_o;

  tb_clk_gen u_clk_gen (
    .clk_o(clk)
  );

  controller_standby_i3c u_controller_standby_i3c (
    .clk_i(clk), .rst_n_i(rst_n), .ctrl_scl_i(scl_bus), .ctrl_sda_i(sda_bus),
    .ctrl_scl_o(scl_o), .ctrl_sda_o(sda_o), .i3c_standby_en_i(standby_en),
    .timing_i(timing), .addr_cfg_i(addr_cfg),
    .rx_queue_wvalid_o(rx_wvalid), .rx_queue_wready_i(rx_wready),
    .rx_queue_wdata_o(rx_wdata), .tx_queue_rvalid_i(tx_rvalid),
    .tx_queue_rready_o(tx_rready), .tx_queue_rdata_i(tx_rdata),
    .event_cmd_complete_o(ev_cmd), .event_read_cmd_received_o(ev_rd),
    .event_target_nack_o(ev_nack), .event_unexp_stop_o(ev_unexp),
    .bus_available_o(bus_avail), .bus_idle_o(bus_idle)
  );

  function automatic int unsigned lcg_next(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // RX queue model with random ready
  // A word counts when it meets the ready driven at this edge
  always @(negedge clk) begin
    lcg_state = lcg_next(lcg_state);
    rx_wready = !stall_q && lcg_state[16];
    if (rx_wvalid && rx_wready) begin
      rx_q.push_back(rx_wdata);
    end
  end

  // TX queue model whose pop takes effect at the following posedge
  always @(negedge clk) begin
    if (tx_pop) begin
      tx_idx = tx_idx + 1;
    end
    tx_rvalid = tx_idx < tx_count;
    tx_rdata  = tx_rvalid ? tx_words[tx_idx] : '0;
    tx_pop    = tx_rready && tx_rvalid;
  end

  always @(negedge clk) begin
    if (ev_cmd) cnt_cmd++;
    if (ev_rd) cnt_rd++;
    if (ev_nack) cnt_nack++;
    if (ev_unexp) cnt_unexp++;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    assert (got === exp) else
      stop_on_error($sformatf("[FAIL] t=%0t: %s is %0h, expected %0h", $time, what, got, exp));
  endtask

  function automatic bit cond_met(input int sel, input int target);
    case (sel)
      COND_IDLE:  return bus_idle;
      COND_AVAIL: return bus_avail;
      COND_BUSY:  return !bus_idle && !bus_avail;
      default:    return rx_q.size() >= target;
    endcase
  endfunction

  task automatic wait_until(input int sel, input int target, input string what);
    int cycles;
    cycles = 0;
    while (!cond_met(sel, target)) begin
      if (cycles >= TIMEOUT) begin
        stop_on_error($sformatf("Timed out after %0d cycles waiting for %s", TIMEOUT, what));
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  // One SCL period of 20 low and 20 high cycles with SDA set mid low phase
  task automatic clock_bit(input logic b, output logic s);
    repeat (10) @(negedge clk);
    sda_m = b;
    repeat (10) @(negedge clk);
    scl_m = 1'b1;
    repeat (19) @(negedge clk);
    s = sda_bus;
    @(negedge clk);
    scl_m = 1'b0;
  endtask

  task automatic send_start();
    repeat (20) @(negedge clk);
    sda_m = 1'b0;
    repeat (20) @(negedge clk);
    scl_m = 1'b0;
  endtask

  task automatic send_stop();
    repeat (10) @(negedge clk);
    sda_m = 1'b0;
    repeat (10) @(negedge clk);
    scl_m = 1'b1;
    repeat (20) @(negedge clk);
    sda_m = 1'b1;
    repeat (20) @(negedge clk);
  endtask

  task automatic send_byte(input logic [7:0] b, output logic ack);
    logic s;
    int   k;
    for (k = 7; k >= 0; k--) begin
      clock_bit(b[k], s);
    end
    clock_bit(1'b1, s);
    ack = !s;
  endtask

  // Master ACKs every byte but the last
  task automatic recv_byte(input logic last, output logic [7:0] b);
    logic s;
    int   k;
    for (k = 7; k >= 0; k--) begin
      clock_bit(1'b1, s);
      b[k] = s;
    end
    clock_bit(last, s);
  endtask

  task automatic run_row(input int idx, input xfer_t r);
    int                    base_cmd;
    int                    base_rd;
    int                    base_nack;
    int                    base_unexp;
    int                    base_rx;
    int                    n_acc;
    int                    n_words;
    int                    i;
    int                    b;
    logic                  ack;
    logic                  s;
    logic [7:0]            got;
    i3c_target_pkg::word_t exp_word;
    base_cmd   = cnt_cmd;
    base_rd    = cnt_rd;
    base_nack  = cnt_nack;
    base_unexp = cnt_unexp;
    base_rx    = rx_q.size();
    tx_count   = tx_count + r.n_tx;
    stall_q    = r.stall;

    send_start();
    wait_until(COND_BUSY, 0, "bus idle and available to drop at START");
    send_byte({r.addr, r.rw}, ack);
    check_value(ack, r.exp_ack, $sformatf("row %0d address ACK", idx));
    if (ack) begin
      for (i = 0; i < r.abort_bits; i++) begin
        clock_bit(i[0], s);
      end
    end
    i = 0;
    while (ack && !r.rw && i < r.n_bytes) begin
      send_byte(r.data[i*8 +: 8], ack);
      // A pending word after 4 bytes blocks the next one
      check_value(ack, !(r.stall && i >= 4), $sformatf("row %0d data ACK %0d", idx, i));
      i++;
    end
    while (ack && r.rw && i < r.n_bytes) begin
      recv_byte(i == r.n_bytes - 1, got);
      check_value(got, r.data[i*8 +: 8], $sformatf("row %0d read byte %0d", idx, i));
      i++;
    end
    send_stop();

    wait_until(COND_IDLE, 0, "bus idle after STOP");
    check_value(bus_avail, 1'b0, $sformatf("row %0d bus available before idle", idx));
    wait_until(COND_AVAIL, 0, "bus available after STOP");
    check_value(bus_idle, 1'b1, $sformatf("row %0d bus idle with available", idx));
    stall_q = 1'b0;

    if (!r.exp_ack || r.rw) begin
      n_acc = 0;
    end else if (r.stall && r.n_bytes > 4) begin
      n_acc = 4;
    end else begin
      n_acc = r.n_bytes;
    end
    n_words = (n_acc + 3) / 4;
    wait_until(COND_WORDS, base_rx + n_words, "RX queue words");
    check_value(rx_q.size() - base_rx, n_words, $sformatf("row %0d RX word count", idx));
    for (i = 0; i < n_words; i++) begin
      exp_word = '0;
      for (b = 0; b < 4; b++) begin
        if (4 * i + b < n_acc) begin
          exp_word[8*b +: 8] = r.data[8*(4*i+b) +: 8];
        end
      end
      check_value(rx_q[base_rx+i], exp_word, $sformatf("row %0d RX word %0d", idx, i));
    end

    check_value(cnt_cmd - base_cmd, r.exp_ack, $sformatf("row %0d cmd_complete", idx));
    check_value(cnt_rd - base_rd, r.rw && r.exp_ack, $sformatf("row %0d read_cmd", idx));
    check_value(cnt_nack - base_nack, r.stall && r.n_bytes > 4,
                $sformatf("row %0d target_nack", idx));
    check_value(cnt_unexp - base_unexp, r.abort_bits != 0,
                $sformatf("row %0d unexp_stop", idx));
  endtask

  task automatic load_table();
    rows[0] = {1'b0, 7'h22, 4'd6, 64'h0000_0605_0403_0201, 1'b1, 1'b0, 4'd0, 2'd0};
    rows[1] = {1'b0, 7'h5A, 4'd3, 64'h0000_0000_00A2_A1A0, 1'b1, 1'b0, 4'd0, 2'd0};
    rows[2] = {1'b0, 7'h33, 4'd2, 64'h0000_0000_0000_BBAA, 1'b0, 1'b0, 4'd0, 2'd0};
    rows[3] = {1'b1, 7'h22, 4'd6, 64'h0000_6655_4433_2211, 1'b1, 1'b0, 4'd0, 2'd2};
    // Empty TX queue reads as all ones
    rows[4] = {1'b1, 7'h22, 4'd1, 64'h0000_0000_0000_00FF, 1'b1, 1'b0, 4'd0, 2'd0};
    rows[5] = {1'b0, 7'h22, 4'd6, 64'h0000_C5C4_C3C2_C1C0, 1'b1, 1'b1, 4'd0, 2'd0};
    rows[6] = {1'b0, 7'h5A, 4'd0, 64'h0, 1'b1, 1'b0, 4'd3, 2'd0};
  endtask

  initial begin
    int r;
    load_table();
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    repeat (5) @(negedge clk);
    // Outputs at rest after reset
    check_value(scl_o, 1'b1, "SCL output after reset");
    check_value(sda_o, 1'b1, "SDA output after reset");
    check_value(rx_wvalid, 1'b0, "RX queue valid after reset");
    check_value(tx_rready, 1'b0, "TX queue ready after reset");
    check_value({ev_cmd, ev_rd, ev_nack, ev_unexp}, 4'b0, "events after reset");
    for (r = 0; r < N_ROWS; r++) begin
      run_row(r, rows[r]);
    end
    $display("Regression passed");
    $finish;
  end

endmodule

//--- verilog.f
src/i3c_target_pkg.sv
src/bus_monitor.sv
src/bus_timers.sv
src/addr_match.sv
src/i3c_target_fsm.sv
src/flow_standby_i3c.sv
src/controller_standby_i3c.sv
sim/tb_clk_gen.sv
sim/tb_controller_standby_i3c.sv
